//--- verilog/div_pkg.sv
package div_pkg;

    localparam int XLEN = 32;
    localparam int NREGS = 32;
    localparam int ADDR_W = $clog2(NREGS);
    localparam int LEN_W = $clog2(XLEN) + 1; // Lengths run from 0 up to XLEN inclusive.

    typedef logic [XLEN-1:0] word_t;
    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [LEN_W-1:0] bit_len_t;

    // Operands as the prepare stage leaves them for the divide loop.
    typedef struct packed {
        logic valid;
        logic rem_op;
        logic neg_quot;
        logic neg_rem;
        logic early;
        word_t early_quot;
        word_t early_rem;
        word_t dividend;
        word_t divisor;
        bit_len_t shift;
        reg_addr_t rd;
    } prep_t;

    typedef struct packed {
        logic valid;
        logic rem_op;
        logic neg_quot;
        logic neg_rem;
        word_t quot;
        word_t rem;
        reg_addr_t rd;
    } iter_t;

    typedef struct packed {
        logic valid;
        reg_addr_t addr;
        word_t data;
    } wb_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } iter_state_t;

endpackage

//--- verilog/div_regfile.sv
`timescale 1ns/1ns

module div_regfile (
    input logic clk,
    input logic rstn,
    input div_pkg::reg_addr_t ra,
    input div_pkg::reg_addr_t rb,
    output div_pkg::word_t a,
    output div_pkg::word_t b,
    input div_pkg::wb_t wb,
    input logic host_we,
    input div_pkg::reg_addr_t host_addr,
    input div_pkg::word_t host_data
);
    import div_pkg::*;

    word_t regs [NREGS];

    // A divide result wins over a host write landing in the same cycle.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.addr] <= wb.data;
        end else if (host_we) begin
            regs[host_addr] <= host_data;
        end
    end

    // x0 is hardwired to zero whatever was written into it.
    always_comb begin
        a = (ra == '0) ? '0 : regs[ra];
        b = (rb == '0) ? '0 : regs[rb];
    end

endmodule

//--- verilog/div_prep.sv
`timescale 1ns/1ns

module div_prep (
    input logic clk,
    input logic rstn,
    input logic en,
    input logic rem_op,
    input logic sign,
    input div_pkg::reg_addr_t rd,
    input div_pkg::word_t a,
    input div_pkg::word_t b,
    input logic take,
    output logic stall,
    output div_pkg::prep_t out
);
    import div_pkg::*;

    word_t mag_a;
    word_t mag_b;
    bit_len_t len_a;
    bit_len_t len_b;
    logic div_zero;
    logic accept;
    prep_t next;

    // Position of the highest set bit plus one, zero for a zero word.
    function automatic bit_len_t bit_length(word_t w);
        bit_len_t len;
        len = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (w[i]) len = bit_len_t'(i + 1);
        end
        return len;
    endfunction

    assign stall = out.valid && !take; // Slot is full and the loop is busy.
    assign accept = en && !stall;

    always_comb begin
        mag_a = (sign && a[XLEN-1]) ? -a : a;
        mag_b = (sign && b[XLEN-1]) ? -b : b;
        len_a = bit_length(mag_a);
        len_b = bit_length(mag_b);
        div_zero = (mag_b == '0);

        next.valid = 1'b1;
        next.rem_op = rem_op;
        next.early = div_zero || (len_a < len_b);
        // An early result is final as it stands, so no sign fix-up is wanted.
        next.neg_quot = !next.early && sign && (a[XLEN-1] ^ b[XLEN-1]);
        next.neg_rem = !next.early && sign && a[XLEN-1];
        next.early_quot = div_zero ? '1 : '0;
        next.early_rem = a;
        next.dividend = mag_a;
        next.divisor = mag_b;
        next.shift = len_a - len_b;
        next.rd = rd;
    end

    // The slot refills in the same cycle its item moves on.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            out.valid <= 1'b0;
        end else if (accept) begin
            out <= next;
        end else if (take) begin
            out.valid <= 1'b0;
        end
    end

endmodule

//--- verilog/div_iter.sv
`timescale 1ns/1ns

module div_iter (
    input logic clk,
    input logic rstn,
    input div_pkg::prep_t in,
    output logic take,
    output div_pkg::iter_t out
);
    import div_pkg::*;

    iter_state_t state;
    bit_len_t cnt;
    logic load;
    word_t rem;
    word_t divisor;
    word_t quot;
    logic rem_op;
    logic neg_quot;
    logic neg_rem;
    reg_addr_t rd;

    assign take = (state == IDLE);
    assign load = take && in.valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (in.valid) begin
                        state <= in.early ? DONE : RUN;
                        cnt <= in.shift;
                    end
                end
                RUN: begin
                    if (cnt == '0) begin
                        state <= DONE; // That was the last quotient bit.
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // One restoring step per RUN cycle, with the divisor aligned to the dividend on load.
    always_ff @(posedge clk) begin
        if (load) begin
            rem_op <= in.rem_op;
            neg_quot <= in.neg_quot;
            neg_rem <= in.neg_rem;
            rd <= in.rd;
            rem <= in.early ? in.early_rem : in.dividend;
            quot <= in.early ? in.early_quot : '0;
            divisor <= in.divisor << in.shift;
        end else if (state == RUN) begin
            if (rem >= divisor) begin
                rem <= rem - divisor;
                quot <= {quot[XLEN-2:0], 1'b1};
            end else begin
                quot <= {quot[XLEN-2:0], 1'b0};
            end
            divisor <= divisor >> 1;
        end
    end

    always_comb begin
        out.valid = (state == DONE);
        out.rem_op = rem_op;
        out.neg_quot = neg_quot;
        out.neg_rem = neg_rem;
        out.quot = quot;
        out.rem = rem;
        out.rd = rd;
    end

endmodule

//--- verilog/div_fixup.sv
`timescale 1ns/1ns

module div_fixup (
    input logic clk,
    input logic rstn,
    input div_pkg::iter_t in,
    output div_pkg::wb_t out
);
    import div_pkg::*;

    word_t quot;
    word_t rem;
    word_t result;

    // Quotient sign is the XOR of the operand signs and the remainder follows the dividend.
    always_comb begin
        quot = in.neg_quot ? -in.quot : in.quot;
        rem = in.neg_rem ? -in.rem : in.rem;
        result = in.rem_op ? rem : quot;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
            if (in.valid) begin
                out.addr <= in.rd;
                out.data <= result;
            end
        end
    end

endmodule

//--- verilog/div_unit.sv
`timescale 1ns/1ns

module div_unit (
    input logic clk,
    input logic rstn,
    input logic en,
    input logic rem_op,
    input logic sign,
    input div_pkg::reg_addr_t rs1,
    input div_pkg::reg_addr_t rs2,
    input div_pkg::reg_addr_t rd,
    input logic host_we,
    input div_pkg::reg_addr_t host_addr,
    input div_pkg::word_t host_data,
    output logic stall,
    output div_pkg::wb_t wb
);
    import div_pkg::*;

    word_t src_a;
    word_t src_b;
    prep_t prep_out;
    iter_t iter_out;
    logic take;

    // Operands are read in the issue cycle and written back from the fix-up stage.
    div_regfile regs (
        .clk(clk),
        .rstn(rstn),
        .ra(rs1),
        .rb(rs2),
        .a(src_a),
        .b(src_b),
        .wb(wb),
        .host_we(host_we),
        .host_addr(host_addr),
        .host_data(host_data)
    );

    div_prep prep (
        .clk(clk),
        .rstn(rstn),
        .en(en),
        .rem_op(rem_op),
        .sign(sign),
        .rd(rd),
        .a(src_a),
        .b(src_b),
        .take(take),
        .stall(stall),
        .out(prep_out)
    );

    div_iter iter (
        .clk(clk),
        .rstn(rstn),
        .in(prep_out),
        .take(take),
        .out(iter_out)
    );

    div_fixup fixup (
        .clk(clk),
        .rstn(rstn),
        .in(iter_out),
        .out(wb)
    );

endmodule

//--- test/div_tb.sv
`timescale 1ns/1ns

module div_tb;
    import div_pkg::*;

    localparam int BATCH = 8;
    localparam int RANDOM_ROWS = 200;
    localparam int CHAIN_ROWS = 6;
    localparam int CYCLES_PER_ROW = 40;
    localparam int MARGIN_CYCLES = 200;

    typedef struct packed {
        word_t dividend;
        word_t divisor;
        logic rem_op;
        logic sign;
        word_t expected;
    } row_t;

    // Rows that name their registers, so results can feed later divisions.
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic rem_op;
        logic sign;
        word_t expected;
    } chain_row_t;

    logic clk;
    logic rstn;
    logic en;
    logic rem_op;
    logic sign;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic host_we;
    reg_addr_t host_addr;
    word_t host_data;
    logic stall;
    wb_t wb;

    row_t rows[$];
    word_t exp_data_q[$];
    reg_addr_t exp_addr_q[$];
    string exp_name_q[$];
    int limit_cycles;

    row_t directed [30] = '{
        '{32'd100, 32'd7, 1'b0, 1'b0, 32'd14},
        '{32'd100, 32'd7, 1'b1, 1'b0, 32'd2},
        '{32'hFFFFFFFF, 32'd16, 1'b0, 1'b0, 32'h0FFFFFFF},
        '{32'hFFFFFFFF, 32'd16, 1'b1, 1'b0, 32'hF},
        '{32'h80000000, 32'd3, 1'b0, 1'b0, 32'h2AAAAAAA},
        '{32'h80000000, 32'd3, 1'b1, 1'b0, 32'd2},
        '{32'd1000000, 32'd1000, 1'b0, 1'b0, 32'd1000},
        '{32'd1000007, 32'd1000, 1'b1, 1'b0, 32'd7},
        '{32'hFFFFFFF9, 32'd2, 1'b0, 1'b1, 32'hFFFFFFFD},
        '{32'hFFFFFFF9, 32'd2, 1'b1, 1'b1, 32'hFFFFFFFF},
        '{32'd7, 32'hFFFFFFFE, 1'b0, 1'b1, 32'hFFFFFFFD},
        '{32'd7, 32'hFFFFFFFE, 1'b1, 1'b1, 32'd1},
        '{32'hFFFFFFF9, 32'hFFFFFFFE, 1'b0, 1'b1, 32'd3},
        '{32'hFFFFFFF9, 32'hFFFFFFFE, 1'b1, 1'b1, 32'hFFFFFFFF},
        '{32'd7, 32'd2, 1'b0, 1'b1, 32'd3},
        '{32'hFFFFFF9C, 32'd7, 1'b0, 1'b1, 32'hFFFFFFF2},
        '{32'hFFFFFF9C, 32'd7, 1'b1, 1'b1, 32'hFFFFFFFE},
        '{32'h80000000, 32'hFFFFFFFF, 1'b0, 1'b1, 32'h80000000},
        '{32'h80000000, 32'hFFFFFFFF, 1'b1, 1'b1, 32'd0},
        '{32'd1234, 32'd0, 1'b0, 1'b0, 32'hFFFFFFFF},
        '{32'd1234, 32'd0, 1'b1, 1'b0, 32'd1234},
        '{32'hFFFFFFFB, 32'd0, 1'b0, 1'b1, 32'hFFFFFFFF},
        '{32'hFFFFFFFB, 32'd0, 1'b1, 1'b1, 32'hFFFFFFFB},
        '{32'd5, 32'd9, 1'b0, 1'b0, 32'd0},
        '{32'd5, 32'd9, 1'b1, 1'b0, 32'd5},
        '{32'hFFFFFFFB, 32'd9, 1'b1, 1'b1, 32'hFFFFFFFB},
        '{32'hFFFFFFFB, 32'd9, 1'b0, 1'b1, 32'd0},
        '{32'h7FFFFFFF, 32'd1, 1'b0, 1'b0, 32'h7FFFFFFF},
        '{32'hFFFFFFFF, 32'hFFFFFFFF, 1'b0, 1'b0, 32'd1},
        '{32'h80000000, 32'hFFFFFFFF, 1'b1, 1'b0, 32'h80000000}
    };

    // Host preload is x1 = 1000, x2 = 7, x3 = 5. Later rows read earlier results.
    chain_row_t chain [CHAIN_ROWS] = '{
        '{5'd1, 5'd2, 5'd5, 1'b0, 1'b0, 32'd142},
        '{5'd5, 5'd3, 5'd6, 1'b0, 1'b0, 32'd28},
        '{5'd6, 5'd3, 5'd7, 1'b1, 1'b0, 32'd3},
        '{5'd6, 5'd0, 5'd8, 1'b0, 1'b0, 32'hFFFFFFFF},
        '{5'd6, 5'd0, 5'd9, 1'b1, 1'b0, 32'd28},
        '{5'd9, 5'd7, 5'd10, 1'b0, 1'b0, 32'd9}
    };

    div_unit dut (
        .clk(clk),
        .rstn(rstn),
        .en(en),
        .rem_op(rem_op),
        .sign(sign),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .host_we(host_we),
        .host_addr(host_addr),
        .host_data(host_data),
        .stall(stall),
        .wb(wb)
    );

    always #10 clk = ~clk;

    // Division by zero gives all ones or the dividend; signed results truncate toward zero.
    function automatic word_t ref_result(word_t a, word_t b, logic is_rem, logic is_signed);
        longint sa;
        longint sb;
        if (b == '0) return is_rem ? a : '1;
        if (is_signed) begin
            sa = $signed(a);
            sb = $signed(b);
        end else begin
            sa = {32'b0, a};
            sb = {32'b0, b};
        end
        return is_rem ? word_t'(sa % sb) : word_t'(sa / sb); // -2^31 / -1 wraps back to -2^31.
    endfunction

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected)
            fail_run($sformatf("[ERROR] %s: expected %h, got %h", name, expected, actual));
    endtask

    task automatic check_addr(string name, reg_addr_t expected, reg_addr_t actual);
        if (actual !== expected)
            fail_run($sformatf("[ERROR] %s: expected x%0d, got x%0d", name, expected, actual));
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected)
            fail_run($sformatf("[ERROR] %s: expected %b, got %b", name, expected, actual));
    endtask

    task automatic host_write(reg_addr_t addr, word_t data);
        @(negedge clk);
        host_we = 1'b1;
        host_addr = addr;
        host_data = data;
        @(posedge clk);
    endtask

    // The request is held until a rising edge sees stall low.
    task automatic issue(string name, reg_addr_t src_a, reg_addr_t src_b, reg_addr_t dest,
                         logic is_rem, logic is_signed, word_t expected);
        @(negedge clk);
        host_we = 1'b0;
        en = 1'b1;
        rs1 = src_a;
        rs2 = src_b;
        rd = dest;
        rem_op = is_rem;
        sign = is_signed;
        while (stall) @(negedge clk);
        exp_data_q.push_back(expected);
        exp_addr_q.push_back(dest);
        exp_name_q.push_back(name);
        @(posedge clk);
    endtask

    task automatic drain();
        @(negedge clk);
        en = 1'b0;
        while (exp_data_q.size() != 0) @(negedge clk);
    endtask

    // Writebacks are registered, so they are sampled at the falling edge.
    always @(negedge clk) begin
        if (rstn && wb.valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                fail_run("A writeback arrived with no division outstanding.");
            end else begin
                check_addr(exp_name_q[0], exp_addr_q[0], wb.addr);
                check_word(exp_name_q[0], exp_data_q[0], wb.data);
                void'(exp_data_q.pop_front());
                void'(exp_addr_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        fail_run("Timeout: a writeback never arrived.");
    end

    initial begin
        row_t r;
        void'($urandom(48743));
        clk = 1'b0;
        rstn = 1'b0;
        en = 1'b0;
        rem_op = 1'b0;
        sign = 1'b0;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        host_we = 1'b0;
        host_addr = '0;
        host_data = '0;
        limit_cycles = 0;

        foreach (directed[i]) rows.push_back(directed[i]);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            r.dividend = $urandom();
            r.divisor = $urandom() >> ($urandom() % 32); // Spread the loop lengths.
            if (i % 25 == 0) r.divisor = '0;
            r.rem_op = 1'($urandom() % 2);
            r.sign = 1'($urandom() % 2);
            r.expected = ref_result(r.dividend, r.divisor, r.rem_op, r.sign);
            rows.push_back(r);
        end
        limit_cycles = CYCLES_PER_ROW * (rows.size() + CHAIN_ROWS) + MARGIN_CYCLES;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_flag("stall after reset", 1'b0, stall);
        check_flag("wb.valid after reset", 1'b0, wb.valid);

        // Operands sit in x1..x16 and results go to x17..x24.
        for (int base = 0; base < rows.size(); base += BATCH) begin
            for (int k = 0; k < BATCH && base + k < rows.size(); k++) begin
                host_write(reg_addr_t'(1 + 2 * k), rows[base + k].dividend);
                host_write(reg_addr_t'(2 + 2 * k), rows[base + k].divisor);
            end
            for (int k = 0; k < BATCH && base + k < rows.size(); k++) begin
                issue($sformatf("row %0d", base + k), reg_addr_t'(1 + 2 * k),
                      reg_addr_t'(2 + 2 * k), reg_addr_t'(17 + k), rows[base + k].rem_op,
                      rows[base + k].sign, rows[base + k].expected);
            end
            drain();
        end

        host_write(5'd1, 32'd1000);
        host_write(5'd2, 32'd7);
        host_write(5'd3, 32'd5);
        foreach (chain[i]) begin
            issue($sformatf("chain %0d", i), chain[i].rs1, chain[i].rs2, chain[i].rd,
                  chain[i].rem_op, chain[i].sign, chain[i].expected);
            drain();
        end

        repeat (5) @(negedge clk); // Room for a stray writeback to show up.
        $display("All tests passed");
        $finish;
    end

endmodule

//--- files.f
verilog/div_pkg.sv
verilog/div_regfile.sv
verilog/div_prep.sv
verilog/div_iter.sv
verilog/div_fixup.sv
verilog/div_unit.sv
test/div_tb.sv

//--- run.sh
#!/bin/sh
# Build the simulation, run it and look for the pass line in its output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module div_tb -f files.f -o div_sim \
    && ./obj_dir/div_sim | tee /dev/stderr | grep "All tests passed" > /dev/null \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
